// File: logic/ex_pkg.sv
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data path word
  localparam int WORD_W    = 32;
  // Register file write address, 64 entries
  localparam int REGADDR_W = 6;
  // Operator code widths
  localparam int ALU_OP_W  = 4;
  localparam int MULT_OP_W = 2;
  // Low operand B bits used as shift amount
  localparam int SHAMT_W   = 5;

  // Operand and result word
  typedef logic [WORD_W-1:0]    word_t;
  // Full multiplier product
  typedef logic [2*WORD_W-1:0]  dword_t;
  // Register file write address
  typedef logic [REGADDR_W-1:0] regaddr_t;
  // Operator codes
  typedef logic [ALU_OP_W-1:0]  alu_op_t;
  typedef logic [MULT_OP_W-1:0] mult_op_t;

  ////////////////////////////////////////
  // ALU operator codes
  ////////////////////////////////////////

  // Arithmetic and logic
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  // Shifts
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  // Set less than
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  // Branch comparisons
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  ////////////////////////////////////////
  // Multiplier operator codes
  ////////////////////////////////////////

  // Low word, single cycle
  localparam mult_op_t MUL_MUL    = 2'd0;
  // High word variants, two cycles
  localparam mult_op_t MUL_MULH   = 2'd1;
  localparam mult_op_t MUL_MULHSU = 2'd2;
  localparam mult_op_t MUL_MULHU  = 2'd3;

endpackage

// File: logic/ex_alu.sv
module ex_alu (
  input  ex_pkg::alu_op_t operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o
);

  // Adder inputs, subtraction folds into the same adder
  logic                         sub_sel;
  ex_pkg::word_t                adder_b;
  ex_pkg::word_t                adder_result;

  // Shifter
  logic [ex_pkg::SHAMT_W-1:0]   shamt;
  ex_pkg::word_t                sll_result;
  ex_pkg::word_t                srl_result;
  ex_pkg::word_t                sra_result;

  // Comparison flags
  logic                         is_equal;
  logic                         less_signed;
  logic                         less_unsigned;
  logic                         cmp_result;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  assign sub_sel = (operator_i == ex_pkg::ALU_SUB);

  // Two's complement negate of B for subtraction
  assign adder_b      = sub_sel ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + ex_pkg::word_t'(sub_sel);

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  // Only the low bits of B count
  assign shamt = operand_b_i[ex_pkg::SHAMT_W-1:0];

  assign sll_result = operand_a_i << shamt;
  assign srl_result = operand_a_i >> shamt;
  // Arithmetic right shift keeps the sign bit
  assign sra_result = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  // One comparison bit shared by branches and set-less-than
  always_comb begin
    cmp_result = 1'b0;
    case (operator_i)
      ex_pkg::ALU_EQ:   cmp_result = is_equal;
      ex_pkg::ALU_NE:   cmp_result = ~is_equal;
      ex_pkg::ALU_LT,
      ex_pkg::ALU_SLT:  cmp_result = less_signed;
      ex_pkg::ALU_GE:   cmp_result = ~less_signed;
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_SLTU: cmp_result = less_unsigned;
      ex_pkg::ALU_GEU:  cmp_result = ~less_unsigned;
      default:          cmp_result = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      // Add and subtract share the adder
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB: result_o = adder_result;

      // Bitwise logic
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      // Shifts
      ex_pkg::ALU_SLL: result_o = sll_result;
      ex_pkg::ALU_SRL: result_o = srl_result;
      ex_pkg::ALU_SRA: result_o = sra_result;

      // Set-less-than and branch compares return the flag zero extended
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU,
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,
      ex_pkg::ALU_GE,
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_GEU: result_o = ex_pkg::word_t'(cmp_result);

      default:         result_o = '0;
    endcase
  end

endmodule

// File: logic/ex_mult.sv
module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_t operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  // High word takes an extra cycle
  typedef enum logic {
    IDLE,
    FINISH
  } mult_state_e;

  mult_state_e     state_q;
  mult_state_e     state_d;

  // Operand signedness
  logic            sign_a;
  logic            sign_b;
  ex_pkg::dword_t  op_a_ext;
  ex_pkg::dword_t  op_b_ext;
  ex_pkg::dword_t  product;

  logic            is_high;
  logic            capture;
  // Upper word held for the second cycle
  ex_pkg::word_t   high_q;

  ////////////////////////////////////////
  // Product
  ////////////////////////////////////////

  assign is_high = (operator_i != ex_pkg::MUL_MUL);

  // A is signed for MULH and MULHSU, B only for MULH
  assign sign_a = ((operator_i == ex_pkg::MUL_MULH) || (operator_i == ex_pkg::MUL_MULHSU))
                  & op_a_i[ex_pkg::WORD_W-1];
  assign sign_b = (operator_i == ex_pkg::MUL_MULH) & op_b_i[ex_pkg::WORD_W-1];

  assign op_a_ext = {{ex_pkg::WORD_W{sign_a}}, op_a_i};
  assign op_b_ext = {{ex_pkg::WORD_W{sign_b}}, op_b_i};

  // Low 64 bits of the extended product are exact for all signedness modes
  assign product = op_a_ext * op_b_ext;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    capture      = 1'b0;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    result_o     = is_high ? product[2*ex_pkg::WORD_W-1:ex_pkg::WORD_W]
                           : product[ex_pkg::WORD_W-1:0];

    case (state_q)
      IDLE: begin
        // First cycle of a high-word op, stall and capture
        if (enable_i && is_high) begin
          ready_o = 1'b0;
          capture = 1'b1;
          state_d = FINISH;
        end
      end

      FINISH: begin
        // Result comes from the register until EX moves on
        multicycle_o = 1'b1;
        result_o     = high_q;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload register, loaded only on capture
  always_ff @(posedge clk) begin
    if (capture) begin
      high_q <= product[2*ex_pkg::WORD_W-1:ex_pkg::WORD_W];
    end
  end

endmodule

// File: logic/ex_writeback.sv
module ex_writeback (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_en_i,
  input  logic             mult_en_i,
  input  logic             csr_access_i,
  input  logic             lsu_en_i,
  input  ex_pkg::word_t    alu_result_i,
  input  ex_pkg::word_t    mult_result_i,
  input  ex_pkg::word_t    csr_rdata_i,
  input  logic             mult_ready_i,
  input  logic             regfile_alu_we_i,
  input  ex_pkg::regaddr_t regfile_alu_waddr_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,
  input  logic             wb_ready_i,
  input  logic             branch_in_ex_i,
  output logic             regfile_alu_we_fw_o,
  output ex_pkg::regaddr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t    regfile_alu_wdata_fw_o,
  output logic             regfile_we_wb_o,
  output ex_pkg::regaddr_t regfile_waddr_wb_o,
  output ex_pkg::word_t    regfile_wdata_wb_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  // Stage status
  logic             units_ready;
  logic             any_en;
  logic             stage_valid;

  // Load write enable after error masking
  logic             load_we;

  // EX/WB register
  logic             we_q;
  ex_pkg::regaddr_t waddr_q;

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR beats multiplier beats ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////////////////////////
  // Ready and valid
  ////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // A branch can leave EX without going to WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign stage_valid = any_en & units_ready;
  assign ex_valid_o  = stage_valid;

  ////////////////////////////////////////
  // EX/WB register for loads
  ////////////////////////////////////////

  // A bus error cancels the load write
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (stage_valid) begin
      we_q <= load_we;
      if (load_we) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new from EX, drop the old entry
      we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  // Load data arrives straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: logic/ex_stage.sv
module ex_stage (
  input  logic             clk,
  input  logic             rst_n,

  // ALU operation
  input  ex_pkg::alu_op_t  alu_operator_i,
  input  ex_pkg::word_t    alu_operand_a_i,
  input  ex_pkg::word_t    alu_operand_b_i,
  input  logic             alu_en_i,

  // Multiplier operation
  input  ex_pkg::mult_op_t mult_operator_i,
  input  ex_pkg::word_t    mult_operand_a_i,
  input  ex_pkg::word_t    mult_operand_b_i,
  input  logic             mult_en_i,
  output logic             mult_multicycle_o,

  // CSR read value
  input  logic             csr_access_i,
  input  ex_pkg::word_t    csr_rdata_i,

  // LSU side
  input  logic             lsu_en_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,

  // Decode side controls
  input  logic             branch_in_ex_i,
  input  ex_pkg::regaddr_t regfile_alu_waddr_i,
  input  logic             regfile_alu_we_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,
  input  logic             wb_ready_i,

  // Forwarding port to the register file and ID
  output logic             regfile_alu_we_fw_o,
  output ex_pkg::regaddr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t    regfile_alu_wdata_fw_o,

  // Load write-back port
  output logic             regfile_we_wb_o,
  output ex_pkg::regaddr_t regfile_waddr_wb_o,
  output ex_pkg::word_t    regfile_wdata_wb_o,

  // Branch outcome to IF
  output logic             branch_decision_o,

  // Stage handshake levels
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  assign branch_decision_o = alu_cmp_result;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu alu_i (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  // Stage ready tells the multiplier its held word was taken
  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////
  // Result select and EX/WB
  ////////////////////////////////////////

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: testbench/ex_stage_tb.sv
module ex_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Run length
  ////////////////////////////////////////

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int ALU_OPS      = 200;
  localparam int BRANCH_OPS   = 8;
  localparam int MULT_OPS     = 40;
  localparam int PRIO_OPS     = 30;
  localparam int LOAD_OPS     = 40;
  localparam int HOLD_OPS     = 30;
  // A multiplier op is given up to 4 cycles, a load up to 2
  localparam int TEST_CYCLES  = RESET_CYCLES + 1 + ALU_OPS + BRANCH_OPS + 4 * MULT_OPS
                                + PRIO_OPS + 2 * LOAD_OPS + 1 + HOLD_OPS + 2;
  localparam int MARGIN       = 50;

  // DUT inputs
  logic             clk;
  logic             rst_n;
  ex_pkg::alu_op_t  alu_operator_i;
  ex_pkg::word_t    alu_operand_a_i;
  ex_pkg::word_t    alu_operand_b_i;
  logic             alu_en_i;
  ex_pkg::mult_op_t mult_operator_i;
  ex_pkg::word_t    mult_operand_a_i;
  ex_pkg::word_t    mult_operand_b_i;
  logic             mult_en_i;
  logic             csr_access_i;
  ex_pkg::word_t    csr_rdata_i;
  logic             lsu_en_i;
  ex_pkg::word_t    lsu_rdata_i;
  logic             lsu_ready_ex_i;
  logic             lsu_err_i;
  logic             branch_in_ex_i;
  ex_pkg::regaddr_t regfile_alu_waddr_i;
  logic             regfile_alu_we_i;
  logic             regfile_we_i;
  ex_pkg::regaddr_t regfile_waddr_i;
  logic             wb_ready_i;

  // DUT outputs
  logic             mult_multicycle_o;
  logic             regfile_alu_we_fw_o;
  ex_pkg::regaddr_t regfile_alu_waddr_fw_o;
  ex_pkg::word_t    regfile_alu_wdata_fw_o;
  logic             regfile_we_wb_o;
  ex_pkg::regaddr_t regfile_waddr_wb_o;
  ex_pkg::word_t    regfile_wdata_wb_o;
  logic             branch_decision_o;
  logic             ex_ready_o;
  logic             ex_valid_o;

  // Reference model state, advanced at each rising edge
  logic             mult_busy_m;
  logic             wb_we_m;
  ex_pkg::regaddr_t wb_waddr_m;

  // Expected values for the current cycle
  logic             exp_fw_check;
  ex_pkg::word_t    exp_fw_data;
  logic             exp_br_check;
  logic             exp_br;
  logic             exp_valid;
  logic             exp_ready;
  logic             exp_mc;
  logic             checks_on;
  logic             seen_ready;

  integer           seed = 32'hebbd_6319;
  int               err_count;
  int               check_count;
  int               test_errors;
  int               test_checks;
  int               test_count;

  ex_stage uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic ex_pkg::word_t rand_word();
    return $random(seed);
  endfunction

  // Branch and set-less-than outcome
  function automatic logic branch_taken(input ex_pkg::alu_op_t op, input ex_pkg::word_t a,
                                        input ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_EQ:                  return a == b;
      ex_pkg::ALU_NE:                  return a != b;
      ex_pkg::ALU_LT, ex_pkg::ALU_SLT:   return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:                  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: return a < b;
      ex_pkg::ALU_GEU:                 return a >= b;
      default:                         return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_t op, input ex_pkg::word_t a,
                                              input ex_pkg::word_t b);
    logic [ex_pkg::SHAMT_W-1:0] sh;
    sh = b[ex_pkg::SHAMT_W-1:0];
    case (op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a - b;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_SLL: return a << sh;
      ex_pkg::ALU_SRL: return a >> sh;
      ex_pkg::ALU_SRA: return ex_pkg::word_t'($signed(a) >>> sh);
      // Compares return the flag in bit 0
      default:         return {31'b0, branch_taken(op, a, b)};
    endcase
  endfunction

  function automatic ex_pkg::word_t product_word(input ex_pkg::mult_op_t op,
                                                 input ex_pkg::word_t a, input ex_pkg::word_t b);
    logic [63:0] p;
    case (op)
      ex_pkg::MUL_MULH:   p = longint'($signed(a)) * longint'($signed(b));
      ex_pkg::MUL_MULHSU: p = longint'($signed(a)) * longint'({32'b0, b});
      default:            p = {32'b0, a} * {32'b0, b};
    endcase
    return (op == ex_pkg::MUL_MUL) ? p[31:0] : p[63:32];
  endfunction

  // Branch bit on top, forwarding data below, CSR over mult over ALU
  function automatic logic [32:0] ref_result(
    input ex_pkg::alu_op_t aop, input ex_pkg::word_t a, input ex_pkg::word_t b,
    input ex_pkg::mult_op_t mop, input ex_pkg::word_t ma, input ex_pkg::word_t mb,
    input logic alu_en, input logic mult_en, input logic csr, input ex_pkg::word_t csr_data);
    ex_pkg::word_t data;
    if (csr) begin
      data = csr_data;
    end else if (mult_en) begin
      data = product_word(mop, ma, mb);
    end else if (alu_en) begin
      data = alu_model(aop, a, b);
    end else begin
      data = '0;
    end
    return {branch_taken(aop, a, b), data};
  endfunction

  ////////////////////////////////////////
  // Cycle model and compare
  ////////////////////////////////////////

  task automatic predict_cycle();
    logic [32:0] ref_out;
    logic        mult_rdy;
    logic        units_rdy;
    logic        any_en;
    // High-word op stalls its first cycle
    mult_rdy  = mult_busy_m || !(mult_en_i && (mult_operator_i != ex_pkg::MUL_MUL));
    units_rdy = mult_rdy && lsu_ready_ex_i && wb_ready_i;
    any_en    = alu_en_i || mult_en_i || csr_access_i || lsu_en_i;
    exp_ready = units_rdy || branch_in_ex_i;
    exp_valid = any_en && units_rdy;
    exp_mc    = mult_busy_m;
    ref_out   = ref_result(alu_operator_i, alu_operand_a_i, alu_operand_b_i, mult_operator_i,
                           mult_operand_a_i, mult_operand_b_i, alu_en_i, mult_en_i,
                           csr_access_i, csr_rdata_i);
    exp_br       = ref_out[32];
    exp_fw_data  = ref_out[31:0];
    exp_fw_check = mult_rdy;
    exp_br_check = (alu_operator_i >= ex_pkg::ALU_EQ);
  endtask

  task automatic update_model();
    if (!rst_n) begin
      mult_busy_m = 1'b0;
      wb_we_m     = 1'b0;
      wb_waddr_m  = '0;
    end else begin
      if (mult_busy_m) begin
        if (exp_ready) mult_busy_m = 1'b0;
      end else if (mult_en_i && (mult_operator_i != ex_pkg::MUL_MUL)) begin
        mult_busy_m = 1'b1;
      end
      // Load entry, error masks the write
      if (exp_valid) begin
        wb_we_m = regfile_we_i && !lsu_err_i;
        if (wb_we_m) wb_waddr_m = regfile_waddr_i;
      end else if (wb_ready_i) begin
        wb_we_m = 1'b0;
      end
    end
  endtask

  // Inputs already set at this falling edge
  task automatic drive_cycle();
    predict_cycle();
    checks_on = 1'b1;
    @(posedge clk);
    update_model();
    @(negedge clk);
  endtask

  task automatic check_value(input string what, input ex_pkg::word_t expected,
                             input ex_pkg::word_t actual);
    check_count++;
    test_checks++;
    if (actual !== expected) begin
      err_count++;
      test_errors++;
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    seen_ready = ex_ready_o;
    check_value("fw we", ex_pkg::word_t'(regfile_alu_we_i),
                ex_pkg::word_t'(regfile_alu_we_fw_o));
    check_value("fw waddr", ex_pkg::word_t'(regfile_alu_waddr_i),
                ex_pkg::word_t'(regfile_alu_waddr_fw_o));
    if (exp_fw_check) check_value("fw data", exp_fw_data, regfile_alu_wdata_fw_o);
    if (exp_br_check) begin
      check_value("branch decision", ex_pkg::word_t'(exp_br), ex_pkg::word_t'(branch_decision_o));
    end
    check_value("ex_valid", ex_pkg::word_t'(exp_valid), ex_pkg::word_t'(ex_valid_o));
    check_value("ex_ready", ex_pkg::word_t'(exp_ready), ex_pkg::word_t'(ex_ready_o));
    check_value("mult multicycle", ex_pkg::word_t'(exp_mc), ex_pkg::word_t'(mult_multicycle_o));
    check_value("wb we", ex_pkg::word_t'(wb_we_m), ex_pkg::word_t'(regfile_we_wb_o));
    check_value("wb waddr", ex_pkg::word_t'(wb_waddr_m), ex_pkg::word_t'(regfile_waddr_wb_o));
    check_value("wb wdata", lsu_rdata_i, regfile_wdata_wb_o);
  endtask

  // Sample midway through the low phase, inputs and state settled
  initial begin
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (checks_on) compare_outputs();
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic clear_inputs();
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_pkg::MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic reset_sequence();
    int n;
    for (n = 0; n < RESET_CYCLES; n++) drive_cycle();
    rst_n = 1'b1;
    // First idle cycle out of reset
    drive_cycle();
    finish_test("reset");
  endtask

  task automatic alu_sweep();
    ex_pkg::word_t r;
    int            n;
    for (n = 0; n < ALU_OPS; n++) begin
      r = rand_word();
      alu_en_i            = 1'b1;
      regfile_alu_we_i    = 1'b1;
      alu_operator_i      = r[3:0];
      regfile_alu_waddr_i = r[9:4];
      alu_operand_a_i     = rand_word();
      // Equal operands now and then
      alu_operand_b_i     = (r[12:10] == 3'd0) ? alu_operand_a_i : rand_word();
      drive_cycle();
    end
    // Branch leaves EX while WB stalls
    for (n = 0; n < BRANCH_OPS; n++) begin
      r = rand_word();
      alu_operator_i  = {1'b1, r[2:0]};
      alu_operand_a_i = rand_word();
      alu_operand_b_i = r[3] ? alu_operand_a_i : rand_word();
      branch_in_ex_i  = 1'b1;
      wb_ready_i      = 1'b0;
      drive_cycle();
    end
    clear_inputs();
    finish_test("alu");
  endtask

  task automatic mult_sequence();
    ex_pkg::word_t r;
    int            n;
    int            cycles;
    int            want;
    for (n = 0; n < MULT_OPS; n++) begin
      r = rand_word();
      mult_en_i           = 1'b1;
      mult_operator_i     = r[1:0];
      regfile_alu_we_i    = 1'b1;
      regfile_alu_waddr_i = r[7:2];
      mult_operand_a_i    = rand_word();
      mult_operand_b_i    = rand_word();
      want   = (r[1:0] == ex_pkg::MUL_MUL) ? 1 : 2;
      cycles = 0;
      // Hold the op until the stage takes it
      do begin
        drive_cycle();
        cycles++;
      end while (!seen_ready && cycles < 4);
      check_value("mult latency", ex_pkg::word_t'(want), ex_pkg::word_t'(cycles));
    end
    clear_inputs();
    finish_test("mult");
  endtask

  task automatic priority_sweep();
    ex_pkg::word_t r;
    int            n;
    for (n = 0; n < PRIO_OPS; n++) begin
      r = rand_word();
      case (n % 5)
        0:       {csr_access_i, mult_en_i, alu_en_i} = 3'b110;
        1:       {csr_access_i, mult_en_i, alu_en_i} = 3'b101;
        2:       {csr_access_i, mult_en_i, alu_en_i} = 3'b111;
        3:       {csr_access_i, mult_en_i, alu_en_i} = 3'b011;
        default: {csr_access_i, mult_en_i, alu_en_i} = 3'b000;
      endcase
      alu_operator_i   = r[3:0];
      alu_operand_a_i  = rand_word();
      alu_operand_b_i  = rand_word();
      mult_operator_i  = ex_pkg::MUL_MUL;
      mult_operand_a_i = rand_word();
      mult_operand_b_i = rand_word();
      csr_rdata_i      = rand_word();
      regfile_alu_we_i = 1'b1;
      drive_cycle();
    end
    clear_inputs();
    finish_test("priority");
  endtask

  task automatic load_writeback();
    ex_pkg::word_t r;
    int            n;
    for (n = 0; n < LOAD_OPS; n++) begin
      r = rand_word();
      lsu_en_i        = 1'b1;
      regfile_we_i    = r[0];
      lsu_err_i       = (r[3:1] == 3'd0);
      regfile_waddr_i = r[9:4];
      lsu_rdata_i     = rand_word();
      drive_cycle();
      if (r[10]) begin
        // Idle cycle flushes the entry
        clear_inputs();
        lsu_rdata_i = rand_word();
        drive_cycle();
      end
    end
    clear_inputs();
    drive_cycle();
    finish_test("load");
  endtask

  task automatic backpressure_hold();
    ex_pkg::word_t r;
    int            n;
    // Park a live entry in WB
    r = rand_word();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = r[5:0];
    drive_cycle();
    for (n = 0; n < HOLD_OPS; n++) begin
      r = rand_word();
      lsu_en_i        = r[0];
      alu_en_i        = r[1];
      mult_en_i       = r[2];
      mult_operator_i = ex_pkg::MUL_MUL;
      regfile_we_i    = 1'b1;
      regfile_waddr_i = r[9:4];
      lsu_rdata_i     = rand_word();
      // At least one of the two stalls is active
      lsu_ready_ex_i  = r[10];
      wb_ready_i      = ~r[10] & r[11];
      drive_cycle();
    end
    clear_inputs();
    drive_cycle();
    finish_test("backpressure");
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    err_count   = 0;
    check_count = 0;
    test_errors = 0;
    test_checks = 0;
    test_count  = 0;
    checks_on   = 1'b0;
    seen_ready  = 1'b0;
    mult_busy_m = 1'b0;
    wb_we_m     = 1'b0;
    wb_waddr_m  = '0;
    rst_n       = 1'b0;
    clear_inputs();
    @(negedge clk);
    reset_sequence();
    alu_sweep();
    mult_sequence();
    priority_sweep();
    load_writeback();
    backpressure_hold();
    checks_on = 1'b0;
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Simulation timed out after %0d cycles", TEST_CYCLES + MARGIN);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: sim.f
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage.sv
testbench/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module ex_stage_tb -o ex_stage_sim \
  && ./obj_dir/ex_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
